// ==== pcie_cfg_top.f ====
hw/pcie_cfg_pkg.sv
hw/cfg_cmd_decode.sv
hw/cfg_mgmt_seq.sv
hw/cfg_reg_file.sv
hw/cfg_resp_fifo.sv
hw/pcie_cfg_top.sv
sim/pcie_cfg_checker.sv
sim/pcie_cfg_tb.sv

// ==== Makefile ====
# Verilator build and run for the PCIe config block

SRCS := $(wildcard hw/*.sv sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vpcie_cfg_tb: pcie_cfg_top.f $(SRCS)
	verilator --binary --timing --assert --top-module pcie_cfg_tb \
		-f pcie_cfg_top.f -o Vpcie_cfg_tb

run: obj_dir/Vpcie_cfg_tb
	./obj_dir/Vpcie_cfg_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/pcie_cfg_tb.sv ====
// ----------------------------------------
// Testbench for the PCIe config block
// Core model, shadow registers, response check
// ----------------------------------------
`timescale 1ns/100ps

module pcie_cfg_tb;
    import pcie_cfg_pkg::*;

    localparam logic [63:0] DSN_VAL = 64'h0123_4567_89ab_cdef;
    localparam int          MAX_CYCLES = 4000;

    logic          clk_pcie;
    logic          rst;
    cmd_word_t     i_cmd;
    logic          i_cmd_valid;
    logic          o_cmd_ready;
    cfg_resp_t     o_resp;
    logic          o_resp_valid;
    logic          i_resp_ready;
    pcie_stat_t    i_stat;
    dw_data_t      i_cfg_mgmt_do;
    logic          i_cfg_mgmt_rd_wr_done;
    cfg_mgmt_req_t o_mgmt;
    logic          o_cfg_mgmt_rd_en;
    logic          o_cfg_mgmt_wr_en;
    logic [63:0]   o_cfg_dsn;
    logic [15:0]   o_pcie_id;

    logic [191:0]  shadow_rw;          // Host view of the RW space
    dw_data_t      model_mem [1024];   // Core config space
    cfg_result_t   exp_res;
    cfg_resp_t     exp_q [$];
    cfg_resp_t     exp_r;
    logic [31:0]   rng_state;
    int            errors;
    int            cycles;
    int            access_count;
    int            delay;
    int            prev;
    logic [15:0]   off;
    dw_addr_t      dw;
    dw_data_t      old_data;

    pcie_cfg_top #(
        .RESP_DEPTH (8),
        .DSN_RESET  (DSN_VAL)
    ) pcie_cfg_top_inst (.*);

    always #10 clk_pcie = ~clk_pcie;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Expected response from the register map
    function automatic cfg_resp_t expected_resp(input reg_addr_t addr);
        logic [223:0] ro;
        logic [14:0]  byte_off;
        reg_data_t    field;
        byte_off = addr[14:0];
        ro = {exp_res.data, 16'h0000, exp_res.byte_en, exp_res.valid, 1'b0,
              exp_res.dwaddr, i_stat.status, i_stat.command, i_cfg_mgmt_do,
              i_stat.link, i_stat.bus, i_stat.dev, i_stat.func, 32'd28,
              16'h0000, RO_MAGIC};
        field = 16'h0000;
        if (addr[15] && byte_off <= 15'd22)
            field = shadow_rw[byte_off*8 +: 16];
        else if (!addr[15] && byte_off <= 15'd26)
            field = ro[byte_off*8 +: 16];
        return '{addr: addr, data: {field[7:0], field[15:8]}};
    endfunction

    task automatic send_cmd(input reg_addr_t addr, input reg_data_t mask,
                            input reg_data_t value, input logic rd, input logic wr);
        i_cmd = '0;
        i_cmd[63:48] = {value[7:0], value[15:8]};
        i_cmd[47:32] = {mask[7:0], mask[15:8]};
        i_cmd[31:16] = addr;
        i_cmd[13]    = wr;
        i_cmd[12]    = rd;
        i_cmd_valid  = 1'b1;
        @(posedge clk_pcie);
        while (!o_cmd_ready)
            @(posedge clk_pcie);
        if (rd)
            exp_q.push_back(expected_resp(addr));
        if (wr && addr[15])
        begin
            shadow_rw = (shadow_rw & ~(192'(mask) << (addr[14:0] * 8)))
                      | (192'(value & mask) << (addr[14:0] * 8));
        end
        #2 i_cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(posedge clk_pcie);
        repeat (3) @(posedge clk_pcie);
        #2;
    endtask

    // ----------------------------------------
    // Core model
    // ----------------------------------------
    initial
    begin
        forever
        begin
            @(posedge clk_pcie);
            if (!rst && (o_cfg_mgmt_rd_en || o_cfg_mgmt_wr_en))
            begin
                check_value("o_mgmt.dwaddr", o_mgmt.dwaddr, shadow_rw[169:160]);
                check_value("o_mgmt.byte_en", o_mgmt.byte_en, shadow_rw[175:172]);
                check_value("o_mgmt.di", o_mgmt.di, shadow_rw[159:128]);
                check_value("o_mgmt.wr_readonly", o_mgmt.wr_readonly, shadow_rw[170]);
                check_value("o_mgmt.wr_rw1c_as_rw", o_mgmt.wr_rw1c_as_rw, shadow_rw[171]);
                delay = 1 + int'(next_rand() % 6);
                repeat (delay - 1) @(posedge clk_pcie);
                #2;
                i_cfg_mgmt_do = model_mem[o_mgmt.dwaddr];
                if (o_cfg_mgmt_wr_en)
                    model_mem[o_mgmt.dwaddr] = o_mgmt.di;
                i_cfg_mgmt_rd_wr_done = 1'b1;
                access_count++;
                @(posedge clk_pcie);
                #2 i_cfg_mgmt_rd_wr_done = 1'b0;
            end
        end
    end

    // Response comparison
    always @(posedge clk_pcie)
    begin
        if (!rst && o_resp_valid && i_resp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Response arrived with none expected at %0t", $time);
            end
            else
            begin
                exp_r = exp_q.pop_front();
                check_value("o_resp", o_resp, exp_r);
            end
        end
    end

    always @(posedge clk_pcie)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        clk_pcie = 1'b0;
        rst = 1'b1;
        i_cmd = '0;
        i_cmd_valid = 1'b0;
        i_resp_ready = 1'b1;
        i_stat = '{bus: 8'h3c, dev: 5'h11, func: 3'h5, link: 16'h1043,
                   command: 16'h0547, status: 16'h0010};
        i_cfg_mgmt_do = '0;
        i_cfg_mgmt_rd_wr_done = 1'b0;
        rng_state = 32'd54032;
        errors = 0;
        cycles = 0;
        access_count = 0;
        exp_res = '0;
        for (int a = 0; a < 1024; a++)
            model_mem[a] = {a[9:0], ~a[9:0], 12'hc5a};
        shadow_rw = '0;
        shadow_rw[15:0] = RW_MAGIC;
        shadow_rw[47:32] = 16'd24;
        shadow_rw[127:64] = DSN_VAL;
        shadow_rw[175:172] = 4'hf;
        repeat (4) @(posedge clk_pcie);
        #2 rst = 1'b0;

        // Reset values
        check_value("o_resp_valid", o_resp_valid, 1'b0);
        check_value("o_cfg_mgmt_rd_en", o_cfg_mgmt_rd_en, 1'b0);
        check_value("o_cfg_mgmt_wr_en", o_cfg_mgmt_wr_en, 1'b0);
        send_cmd(16'h8000, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h8004, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0004, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0008, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0014, 16'h0000, 16'h0000, 1'b1, 1'b0);
        check_value("o_pcie_id", o_pcie_id, {i_stat.bus, i_stat.dev, i_stat.func});
        check_value("o_cfg_dsn", o_cfg_dsn, DSN_VAL);

        // Random masked writes, start field at +002 left alone
        for (int i = 0; i < 30; i++)
        begin
            off = 16'(next_rand() % 11);
            off = (off == 0) ? 16'h0000 : off * 2 + 2;
            send_cmd(16'h8000 | off, 16'(next_rand()), 16'(next_rand()),
                     next_rand() % 2 == 0, 1'b1);
            send_cmd(16'h8000 | off, 16'h0000, 16'h0000, 1'b1, 1'b0);
        end
        wait_drain();
        check_value("o_cfg_dsn", o_cfg_dsn, shadow_rw[127:64]);

        // RO writes ignored, reads past the end are zero
        send_cmd(16'h0000, 16'hffff, 16'h1234, 1'b0, 1'b1);
        send_cmd(16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h8000, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h8018, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h8040, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h001c, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0100, 16'h0000, 16'h0000, 1'b1, 1'b0);
        wait_drain();

        // Read access with wait-complete, header read held until done
        dw = 10'h0a7;
        send_cmd(16'h8014, 16'hffff, {4'hf, 2'b00, dw}, 1'b0, 1'b1);
        old_data = model_mem[dw];
        prev = access_count;
        exp_res = '{valid: 1'b1, dwaddr: dw, byte_en: 4'hf, data: old_data};
        send_cmd(16'h8002, 16'h0007, 16'h0005, 1'b0, 1'b1);
        send_cmd(16'h8002, 16'h0000, 16'h0000, 1'b1, 1'b0);   // Accepted before the hold
        shadow_rw[16] = 1'b0;
        send_cmd(16'h0014, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0018, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h001a, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h8002, 16'h0000, 16'h0000, 1'b1, 1'b0);
        wait_drain();
        repeat (10) @(posedge clk_pcie);
        #2;
        check_value("access count", access_count, prev + 1);

        // Write access
        dw = 10'h312;
        send_cmd(16'h8014, 16'hffff, {4'hf, 2'b00, dw}, 1'b0, 1'b1);
        send_cmd(16'h8010, 16'hffff, 16'hbeef, 1'b0, 1'b1);
        send_cmd(16'h8012, 16'hffff, 16'h5a17, 1'b0, 1'b1);
        old_data = model_mem[dw];
        prev = access_count;
        send_cmd(16'h8002, 16'h0007, 16'h0006, 1'b0, 1'b1);
        wait (access_count == prev + 1);
        repeat (2) @(posedge clk_pcie);
        #2;
        shadow_rw[17] = 1'b0;
        exp_res = '{valid: 1'b1, dwaddr: dw, byte_en: 4'hf, data: old_data};
        send_cmd(16'h0014, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h0018, 16'h0000, 16'h0000, 1'b1, 1'b0);
        send_cmd(16'h8002, 16'h0000, 16'h0000, 1'b1, 1'b0);
        wait_drain();
        check_value("model_mem", model_mem[dw], 32'h5a17_beef);

        // Back-pressure burst
        i_resp_ready = 1'b0;
        fork
            for (int i = 0; i < 20; i++)
                send_cmd(16'h8000 | 16'((next_rand() % 12) * 2), 16'h0000, 16'h0000,
                         1'b1, 1'b0);
            begin
                repeat (40) @(posedge clk_pcie);
                #2 i_resp_ready = 1'b1;
            end
        join
        wait_drain();

        $display("Checks done with %0d errors", errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== sim/pcie_cfg_checker.sv ====
// ----------------------------------------
// Protocol assertions for the config block
// ----------------------------------------
`timescale 1ns/100ps

module pcie_cfg_checker #(
    parameter int RESP_DEPTH = 8
) (
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        o_cfg_mgmt_rd_en,
    input  logic        o_cfg_mgmt_wr_en,
    input  logic [31:0] o_resp,
    input  logic        o_resp_valid,
    input  logic        i_resp_ready,
    input  logic        o_cmd_ready,
    input  logic        push
);

    logic [7:0] fill;   // Queue entries seen from push and pop

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
            fill <= '0;
        else
            fill <= fill + 8'(push) - 8'(o_resp_valid & i_resp_ready);
    end

    // Only one core access at a time
    a_enables_exclusive: assert property (
        @(posedge clk_pcie) disable iff (rst)
        !(o_cfg_mgmt_rd_en && o_cfg_mgmt_wr_en)
    ) else $error("read and write enables high together");

    // Held response must not change
    a_resp_stable: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (o_resp_valid && !i_resp_ready) |=> $stable(o_resp)
    ) else $error("response changed while stalled");

    a_ready_afull: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (fill >= 8'(RESP_DEPTH - 3)) |-> !o_cmd_ready
    ) else $error("command ready high while queue almost full");

    // A push into a full queue would lose a response
    a_no_overflow: assert property (
        @(posedge clk_pcie) disable iff (rst)
        fill <= 8'(RESP_DEPTH)
    ) else $error("response queue overflow");

endmodule

bind pcie_cfg_top pcie_cfg_checker #(
    .RESP_DEPTH (RESP_DEPTH)
) pcie_cfg_checker_inst (
    .clk_pcie         (clk_pcie),
    .rst              (rst),
    .o_cfg_mgmt_rd_en (o_cfg_mgmt_rd_en),
    .o_cfg_mgmt_wr_en (o_cfg_mgmt_wr_en),
    .o_resp           (o_resp),
    .o_resp_valid     (o_resp_valid),
    .i_resp_ready     (i_resp_ready),
    .o_cmd_ready      (o_cmd_ready),
    .push             (push)
);

// ==== hw/pcie_cfg_top.sv ====
// ----------------------------------------
// PCIe config register block, top level
// Decoder, register file and response queue
// ----------------------------------------
`timescale 1ns/100ps

module pcie_cfg_top #(
    parameter int          RESP_DEPTH = 8,
    parameter logic [63:0] DSN_RESET  = pcie_cfg_pkg::DSN_DEFAULT
) (
    input  logic                        clk_pcie,
    input  logic                        rst,
    // Host command and response
    input  pcie_cfg_pkg::cmd_word_t     i_cmd,
    input  logic                        i_cmd_valid,
    output logic                        o_cmd_ready,
    output pcie_cfg_pkg::cfg_resp_t     o_resp,
    output logic                        o_resp_valid,
    input  logic                        i_resp_ready,
    // PCIe core side
    input  pcie_cfg_pkg::pcie_stat_t    i_stat,
    input  pcie_cfg_pkg::dw_data_t      i_cfg_mgmt_do,
    input  logic                        i_cfg_mgmt_rd_wr_done,
    output pcie_cfg_pkg::cfg_mgmt_req_t o_mgmt,
    output logic                        o_cfg_mgmt_rd_en,
    output logic                        o_cfg_mgmt_wr_en,
    output logic [63:0]                 o_cfg_dsn,
    output logic [15:0]                 o_pcie_id
);
    import pcie_cfg_pkg::*;

    cfg_cmd_t  dec;
    logic      dec_valid;
    cfg_resp_t push_resp;
    logic      push;
    logic      resp_afull;
    logic      hold;

    cfg_cmd_decode cfg_cmd_decode_inst (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .i_cmd        (i_cmd),
        .i_cmd_valid  (i_cmd_valid),
        .o_cmd_ready  (o_cmd_ready),
        .i_resp_afull (resp_afull),
        .i_hold       (hold),
        .o_dec        (dec),
        .o_dec_valid  (dec_valid)
    );

    cfg_reg_file #(
        .DSN_RESET (DSN_RESET)
    ) cfg_reg_file_inst (
        .clk_pcie              (clk_pcie),
        .rst                   (rst),
        .i_dec                 (dec),
        .i_dec_valid           (dec_valid),
        .o_resp                (push_resp),
        .o_push                (push),
        .o_hold                (hold),
        .i_stat                (i_stat),
        .i_cfg_mgmt_do         (i_cfg_mgmt_do),
        .i_cfg_mgmt_rd_wr_done (i_cfg_mgmt_rd_wr_done),
        .o_mgmt                (o_mgmt),
        .o_cfg_mgmt_rd_en      (o_cfg_mgmt_rd_en),
        .o_cfg_mgmt_wr_en      (o_cfg_mgmt_wr_en),
        .o_cfg_dsn             (o_cfg_dsn),
        .o_pcie_id             (o_pcie_id)
    );

    cfg_resp_fifo #(
        .RESP_DEPTH (RESP_DEPTH)
    ) cfg_resp_fifo_inst (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .i_push       (push),
        .i_resp       (push_resp),
        .o_resp       (o_resp),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready),
        .o_afull      (resp_afull)
    );

endmodule

// ==== hw/cfg_resp_fifo.sv ====
// ----------------------------------------
// Response queue, in order, almost-full flag
// ----------------------------------------
`timescale 1ns/100ps

module cfg_resp_fifo #(
    parameter int RESP_DEPTH = 8
) (
    input  logic                    clk_pcie,
    input  logic                    rst,
    input  logic                    i_push,
    input  pcie_cfg_pkg::cfg_resp_t i_resp,
    output pcie_cfg_pkg::cfg_resp_t o_resp,
    output logic                    o_resp_valid,
    input  logic                    i_resp_ready,
    output logic                    o_afull
);
    import pcie_cfg_pkg::*;

    localparam int AW = $clog2(RESP_DEPTH);
    localparam int CW = $clog2(RESP_DEPTH + 1);

    cfg_resp_t       mem [RESP_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign o_resp_valid = (count != '0);
    assign o_resp       = mem[rd_ptr];
    assign do_pop       = o_resp_valid & i_resp_ready;
    assign do_push      = i_push & (count != CW'(RESP_DEPTH));
    assign o_afull      = (count >= CW'(RESP_DEPTH - 3));  // Two more may be in flight

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(RESP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(RESP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(do_push) - CW'(do_pop);
        end
    end

    always_ff @(posedge clk_pcie)
    begin
        if (do_push)
            mem[wr_ptr] <= i_resp;
    end

endmodule

// ==== hw/cfg_reg_file.sv ====
// ----------------------------------------
// Config register file
// RW and RO spaces, masked writes, reads
// ----------------------------------------
`timescale 1ns/100ps

module cfg_reg_file #(
    parameter logic [63:0] DSN_RESET = pcie_cfg_pkg::DSN_DEFAULT
) (
    input  logic                        clk_pcie,
    input  logic                        rst,
    input  pcie_cfg_pkg::cfg_cmd_t      i_dec,
    input  logic                        i_dec_valid,
    output pcie_cfg_pkg::cfg_resp_t     o_resp,
    output logic                        o_push,
    output logic                        o_hold,
    input  pcie_cfg_pkg::pcie_stat_t    i_stat,
    input  pcie_cfg_pkg::dw_data_t      i_cfg_mgmt_do,
    input  logic                        i_cfg_mgmt_rd_wr_done,
    output pcie_cfg_pkg::cfg_mgmt_req_t o_mgmt,
    output logic                        o_cfg_mgmt_rd_en,
    output logic                        o_cfg_mgmt_wr_en,
    output logic [63:0]                 o_cfg_dsn,
    output logic [15:0]                 o_pcie_id
);
    import pcie_cfg_pkg::*;

    localparam int RW_BITS = RW_BYTES * 8;
    localparam int RO_BITS = RO_BYTES * 8;

    // Reset image of the RW space, MSB first
    localparam logic [RW_BITS-1:0] RW_RESET = {
        16'h0000,                           // +016 slack
        BYTE_EN_RESET, 2'b00, 10'h000,      // +014 byte_en, flags, dwaddr
        32'h0000_0000,                      // +010 mgmt_di
        DSN_RESET,                          // +008
        32'(RW_BYTES),                      // +004
        16'h0000,                           // +002 start and wait bits
        RW_MAGIC
    };

    logic [RW_BITS-1:0] rw;
    logic [RO_BITS-1:0] ro;
    logic [RW_BITS-1:0] rw_next;
    logic [RW_BITS-1:0] wr_mask;
    logic [RW_BITS-1:0] wr_val;
    logic [RW_BITS-1:0] clr_mask;
    logic [17:0]        bit_addr;
    logic [14:0]        byte_off;
    logic               in_range;
    reg_data_t          rd_field;
    logic               take_rd;
    logic               take_wr;
    logic               seq_busy;
    cfg_result_t        result;

    // ----------------------------------------
    // Read-only space
    // ----------------------------------------
    assign o_pcie_id = {i_stat.bus, i_stat.dev, i_stat.func};

    assign ro = {
        result.data,                                        // +018
        16'h0000,                                           // +016 slack
        result.byte_en, result.valid, 1'b0, result.dwaddr,  // +014
        i_stat.status,                                      // +012
        i_stat.command,                                     // +010
        i_cfg_mgmt_do,                                      // +00C
        i_stat.link,                                        // +00A
        o_pcie_id,                                          // +008
        32'(RO_BYTES),                                      // +004
        14'h0000, o_cfg_mgmt_wr_en, o_cfg_mgmt_rd_en,       // +002 mirror
        RO_MAGIC
    };

    // ----------------------------------------
    // Outputs toward the core
    // ----------------------------------------
    assign o_cfg_dsn            = rw[RWPOS_DSN +: 64];
    assign o_mgmt.di            = rw[RWPOS_DI +: 32];
    assign o_mgmt.dwaddr        = rw[RWPOS_DWADDR +: 10];
    assign o_mgmt.byte_en       = rw[RWPOS_BYTE_EN +: 4];
    assign o_mgmt.wr_readonly   = rw[RWPOS_WR_RO];
    assign o_mgmt.wr_rw1c_as_rw = rw[RWPOS_RW1C];

    assign o_hold = rw[RWPOS_WAIT_COMPLETE] & seq_busy;

    // ----------------------------------------
    // Access decode
    // ----------------------------------------
    assign byte_off = i_dec.addr[14:0];
    assign bit_addr = {byte_off, 3'b000};
    assign in_range = i_dec.addr[15] ? (byte_off <= 15'(RW_BYTES - 2))
                                     : (byte_off <= 15'(RO_BYTES - 2));

    always_comb
    begin
        rd_field = 16'h0000;                // Past the end reads zero
        if (in_range)
        begin
            rd_field = i_dec.addr[15] ? reg_data_t'(rw >> bit_addr)
                                      : reg_data_t'(ro >> bit_addr);
        end
    end

    // Taken start bits clear, a same cycle host write wins
    assign wr_mask  = (i_dec_valid & i_dec.wr) ? RW_BITS'(i_dec.mask) << bit_addr : '0;
    assign wr_val   = RW_BITS'(i_dec.value) << bit_addr;
    assign clr_mask = (RW_BITS'(take_rd) << RWPOS_RD_EN) | (RW_BITS'(take_wr) << RWPOS_WR_EN);
    assign rw_next  = (rw & ~(wr_mask | clr_mask)) | (wr_val & wr_mask);

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw     <= RW_RESET;
            o_push <= 1'b0;
        end
        else
        begin
            rw     <= rw_next;
            o_push <= i_dec_valid & i_dec.rd;
        end
    end

    // Response sees the field as it was before the write
    always_ff @(posedge clk_pcie)
    begin
        if (i_dec_valid & i_dec.rd)
        begin
            o_resp.addr <= i_dec.addr;
            o_resp.data <= {rd_field[7:0], rd_field[15:8]};
        end
    end

    cfg_mgmt_seq cfg_mgmt_seq_inst (
        .clk_pcie  (clk_pcie),
        .rst       (rst),
        .i_rd_req  (rw[RWPOS_RD_EN]),
        .i_wr_req  (rw[RWPOS_WR_EN]),
        .i_dwaddr  (o_mgmt.dwaddr),
        .i_byte_en (o_mgmt.byte_en),
        .i_done    (i_cfg_mgmt_rd_wr_done),
        .i_do      (i_cfg_mgmt_do),
        .o_take_rd (take_rd),
        .o_take_wr (take_wr),
        .o_rd_en   (o_cfg_mgmt_rd_en),
        .o_wr_en   (o_cfg_mgmt_wr_en),
        .o_busy    (seq_busy),
        .o_result  (result)
    );

endmodule

// ==== hw/cfg_mgmt_seq.sv ====
// ----------------------------------------
// Config management access sequencer
// Starts core accesses, captures the result
// ----------------------------------------
`timescale 1ns/100ps

module cfg_mgmt_seq (
    input  logic                      clk_pcie,
    input  logic                      rst,
    input  logic                      i_rd_req,
    input  logic                      i_wr_req,
    input  pcie_cfg_pkg::dw_addr_t    i_dwaddr,
    input  pcie_cfg_pkg::byte_en_t    i_byte_en,
    input  logic                      i_done,
    input  pcie_cfg_pkg::dw_data_t    i_do,
    output logic                      o_take_rd,
    output logic                      o_take_wr,
    output logic                      o_rd_en,
    output logic                      o_wr_en,
    output logic                      o_busy,
    output pcie_cfg_pkg::cfg_result_t o_result
);
    import pcie_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } seq_state_t;

    seq_state_t state;
    logic       start_ok;

    // Done has priority over any new start
    assign start_ok  = (state == ST_IDLE) & ~i_done;
    assign o_take_rd = start_ok & i_rd_req;
    assign o_take_wr = start_ok & ~i_rd_req & i_wr_req;

    // Enables drop in the done cycle toward the core
    assign o_rd_en = (state == ST_READ) & ~i_done;
    assign o_wr_en = (state == ST_WRITE) & ~i_done;
    assign o_busy  = i_rd_req | i_wr_req | (state != ST_IDLE);

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            o_result <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (o_take_rd)
                    begin
                        state          <= ST_READ;
                        o_result.valid <= 1'b0;    // Old result is stale now
                    end
                    else if (o_take_wr)
                    begin
                        state          <= ST_WRITE;
                        o_result.valid <= 1'b0;
                    end
                end
                ST_READ, ST_WRITE:
                begin
                    if (i_done)
                    begin
                        state    <= ST_IDLE;
                        o_result <= '{valid: 1'b1, dwaddr: i_dwaddr,
                                      byte_en: i_byte_en, data: i_do};
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/cfg_cmd_decode.sv ====
// ----------------------------------------
// Command decoder
// Accepts host words, registers decoded command
// ----------------------------------------
`timescale 1ns/100ps

module cfg_cmd_decode (
    input  logic                     clk_pcie,
    input  logic                     rst,
    input  pcie_cfg_pkg::cmd_word_t  i_cmd,
    input  logic                     i_cmd_valid,
    output logic                     o_cmd_ready,
    input  logic                     i_resp_afull,
    input  logic                     i_hold,
    output pcie_cfg_pkg::cfg_cmd_t   o_dec,
    output logic                     o_dec_valid
);
    import pcie_cfg_pkg::*;

    logic      accept;
    reg_addr_t cmd_addr;
    reg_data_t cmd_mask;
    reg_data_t cmd_value;

    // Room for two in-flight results, no pending access when waiting
    assign o_cmd_ready = ~i_resp_afull & ~i_hold;
    assign accept      = i_cmd_valid & o_cmd_ready;

    // ----------------------------------------
    // Field split
    // ----------------------------------------
    assign cmd_addr  = i_cmd[31:16];
    assign cmd_value = {i_cmd[55:48], i_cmd[63:56]};   // Swap to field order
    assign cmd_mask  = {i_cmd[39:32], i_cmd[47:40]};

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            o_dec_valid <= 1'b0;
        end
        else
        begin
            o_dec_valid <= accept;
        end
    end

    // Payload only, qualified by the strobe
    always_ff @(posedge clk_pcie)
    begin
        if (accept)
        begin
            o_dec.addr  <= cmd_addr;
            o_dec.mask  <= cmd_mask;
            o_dec.value <= cmd_value;
            o_dec.rd    <= i_cmd[12];
            o_dec.wr    <= i_cmd[13] & cmd_addr[15];   // RO space is never written
        end
    end

endmodule

// ==== hw/pcie_cfg_pkg.sv ====
// ----------------------------------------
// PCIe config register block definitions
// Widths, register map and shared structs
// ----------------------------------------
package pcie_cfg_pkg;

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------
    typedef logic [63:0] cmd_word_t;    // Raw host command word
    typedef logic [15:0] reg_addr_t;    // Byte address, bit 15 selects RW space
    typedef logic [15:0] reg_data_t;
    typedef logic [9:0]  dw_addr_t;     // Config space dword address
    typedef logic [31:0] dw_data_t;
    typedef logic [3:0]  byte_en_t;

    // ----------------------------------------
    // Register spaces
    // ----------------------------------------
    localparam int        RW_BYTES      = 24;
    localparam int        RO_BYTES      = 28;
    localparam reg_data_t RW_MAGIC      = 16'h6745;
    localparam reg_data_t RO_MAGIC      = 16'h2301;
    localparam byte_en_t  BYTE_EN_RESET = 4'hf;
    localparam logic [63:0] DSN_DEFAULT = 64'h0000_0001_0200_0c17;

    // Start and control bits at RW +002
    localparam int RWPOS_RD_EN         = 16;
    localparam int RWPOS_WR_EN         = 17;
    localparam int RWPOS_WAIT_COMPLETE = 18;

    // RW field bit positions
    localparam int RWPOS_DSN     = 64;  // +008, 64 bits
    localparam int RWPOS_DI      = 128; // +010, 32 bits
    localparam int RWPOS_DWADDR  = 160; // +014, 10 bits
    localparam int RWPOS_WR_RO   = 170;
    localparam int RWPOS_RW1C    = 171;
    localparam int RWPOS_BYTE_EN = 172; // 4 bits

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t mask;    // Field order, already swapped
        reg_data_t value;
        logic      rd;
        logic      wr;
    } cfg_cmd_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;    // Byte swapped for the host
    } cfg_resp_t;

    typedef struct packed {
        logic [7:0]  bus;
        logic [4:0]  dev;
        logic [2:0]  func;
        logic [15:0] link;
        logic [15:0] command;
        logic [15:0] status;
    } pcie_stat_t;

    typedef struct packed {
        dw_data_t di;
        dw_addr_t dwaddr;
        byte_en_t byte_en;
        logic     wr_readonly;
        logic     wr_rw1c_as_rw;
    } cfg_mgmt_req_t;

    typedef struct packed {
        logic     valid;
        dw_addr_t dwaddr;
        byte_en_t byte_en;
        dw_data_t data;
    } cfg_result_t;

endpackage
